//--- alu_pkg.sv
`default_nettype none

package alu_pkg;

    typedef logic [7:0]  aluop_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;    // hi in upper word

    // cycles from the load cycle to the ready pulse
    localparam int MUL_LATENCY = 33;
    localparam int DIV_LATENCY = 34;

    typedef logic [$clog2(DIV_LATENCY)-1:0] step_t;    // iteration counter

    localparam aluop_t ALUOP_NOP   = 8'h00;

    localparam aluop_t ALUOP_ADD   = 8'h01;
    localparam aluop_t ALUOP_ADDU  = 8'h02;
    localparam aluop_t ALUOP_SUB   = 8'h03;
    localparam aluop_t ALUOP_SUBU  = 8'h04;
    localparam aluop_t ALUOP_SLT   = 8'h05;
    localparam aluop_t ALUOP_SLTU  = 8'h06;
    localparam aluop_t ALUOP_SLTI  = 8'h07;
    localparam aluop_t ALUOP_SLTIU = 8'h08;

    localparam aluop_t ALUOP_AND   = 8'h10;
    localparam aluop_t ALUOP_OR    = 8'h11;
    localparam aluop_t ALUOP_NOR   = 8'h12;
    localparam aluop_t ALUOP_XOR   = 8'h13;
    localparam aluop_t ALUOP_LUI   = 8'h14;

    localparam aluop_t ALUOP_SLL   = 8'h20;
    localparam aluop_t ALUOP_SLLV  = 8'h21;
    localparam aluop_t ALUOP_SRL   = 8'h22;
    localparam aluop_t ALUOP_SRLV  = 8'h23;
    localparam aluop_t ALUOP_SRA   = 8'h24;
    localparam aluop_t ALUOP_SRAV  = 8'h25;
    localparam aluop_t ALUOP_ROTR  = 8'h26;

    localparam aluop_t ALUOP_CLO   = 8'h30;
    localparam aluop_t ALUOP_CLZ   = 8'h31;

    localparam aluop_t ALUOP_MTHI  = 8'h40;
    localparam aluop_t ALUOP_MTLO  = 8'h41;
    localparam aluop_t ALUOP_MFHI  = 8'h42;
    localparam aluop_t ALUOP_MFLO  = 8'h43;
    localparam aluop_t ALUOP_MFC0  = 8'h44;

    // multi-cycle codes
    localparam aluop_t ALUOP_MULT  = 8'h50;
    localparam aluop_t ALUOP_MULTU = 8'h51;
    localparam aluop_t ALUOP_MADD  = 8'h52;
    localparam aluop_t ALUOP_MADDU = 8'h53;
    localparam aluop_t ALUOP_MSUB  = 8'h54;
    localparam aluop_t ALUOP_MSUBU = 8'h55;
    localparam aluop_t ALUOP_DIV   = 8'h56;
    localparam aluop_t ALUOP_DIVU  = 8'h57;

endpackage

`default_nettype wire

//--- mul_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mul_if import alu_pkg::*; ();

    word_t  a;
    word_t  b;
    logic   sign;      // signed operands
    logic   start;
    dword_t result;
    logic   ready;     // one-cycle pulse

    modport ctrl (
        output a, b, sign, start,
        input  result, ready
    );

    modport unit (
        input  a, b, sign, start,
        output result, ready
    );

endinterface

`default_nettype wire

//--- div_if.sv
`timescale 1ns/1ns
`default_nettype none

interface div_if import alu_pkg::*; ();

    word_t  a;         // dividend
    word_t  b;         // divisor
    logic   sign;
    logic   start;
    dword_t result;    // remainder upper, quotient lower
    logic   ready;

    modport ctrl (
        output a, b, sign, start,
        input  result, ready
    );

    modport unit (
        input  a, b, sign, start,
        output result, ready
    );

endinterface

`default_nettype wire

//--- mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_unit import alu_pkg::*; (
    input  logic clk,
    input  logic rst,
    mul_if.unit  mul
);

    typedef enum logic [1:0] {IDLE, BUSY, DONE} state_t;

    state_t state;
    step_t  cnt;
    dword_t prod;
    dword_t mcand;
    word_t  mplier;
    logic   neg;
    word_t  mag_a;
    word_t  mag_b;

    assign mag_a = (mul.sign && mul.a[31]) ? -mul.a : mul.a;
    assign mag_b = (mul.sign && mul.b[31]) ? -mul.b : mul.b;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (mul.start) begin
                        state <= BUSY;
                        cnt   <= '0;
                    end
                end
                BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == step_t'(MUL_LATENCY - 2))
                        state <= DONE;    // last partial product
                end
                default: state <= IDLE;   // ready cycle, start ignored
            endcase
        end
    end

    // one partial product per busy cycle
    always_ff @(posedge clk) begin
        if (state == IDLE && mul.start) begin
            prod   <= '0;
            mcand  <= {32'b0, mag_a};
            mplier <= mag_b;
            neg    <= mul.sign & (mul.a[31] ^ mul.b[31]);
        end else if (state == BUSY) begin
            if (mplier[0])
                prod <= prod + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign mul.result = neg ? -prod : prod;    // sign fix on the magnitude product
    assign mul.ready  = (state == DONE);

endmodule

`default_nettype wire

//--- div_unit.sv
`timescale 1ns/1ns
`default_nettype none

module div_unit import alu_pkg::*; (
    input  logic clk,
    input  logic rst,
    div_if.unit  div
);

    typedef enum logic [1:0] {IDLE, BUSY, FIX, DONE} state_t;

    state_t      state;
    step_t       cnt;
    word_t       rem;
    word_t       quo;      // dividend shifts out, quotient shifts in
    word_t       dvs;
    logic        neg_q;
    logic        neg_r;
    logic        dz;       // zero divisor seen at load
    dword_t      res;
    word_t       mag_a;
    word_t       mag_b;
    logic [32:0] trial;
    logic [32:0] diff;
    word_t       q_signed;
    word_t       r_signed;

    assign mag_a = (div.sign && div.a[31]) ? -div.a : div.a;
    assign mag_b = (div.sign && div.b[31]) ? -div.b : div.b;

    assign trial = {rem, quo[31]};
    assign diff  = trial - {1'b0, dvs};    // bit 32 set means trial < divisor

    assign q_signed = neg_q ? -quo : quo;
    assign r_signed = neg_r ? -rem : rem;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (div.start) begin
                        state <= BUSY;
                        cnt   <= '0;
                    end
                end
                BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == step_t'(DIV_LATENCY - 3))
                        state <= FIX;
                end
                FIX:     state <= DONE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (div.start) begin
                    rem   <= '0;
                    quo   <= mag_a;
                    dvs   <= mag_b;
                    neg_q <= div.sign & (div.a[31] ^ div.b[31]);
                    neg_r <= div.sign & div.a[31];    // remainder follows dividend
                    dz    <= (div.b == '0);
                end
            end
            BUSY: begin
                if (!diff[32]) begin
                    rem <= diff[31:0];
                    quo <= {quo[30:0], 1'b1};
                end else begin
                    rem <= trial[31:0];    // restore
                    quo <= {quo[30:0], 1'b0};
                end
            end
            FIX: begin
                // with a zero divisor rem already holds |dividend|
                res <= {r_signed, dz ? 32'hffff_ffff : q_signed};
            end
            default: ;
        endcase
    end

    assign div.result = res;
    assign div.ready  = (state == DONE);

endmodule

`default_nettype wire

//--- alu_master.sv
`timescale 1ns/1ns
`default_nettype none

module alu_master import alu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  aluop_t aluop,
    input  word_t  a,
    input  word_t  b,
    input  word_t  cp0_data,
    input  dword_t hilo,
    mul_if.ctrl    mul,
    div_if.ctrl    div,
    output logic   stall,
    output word_t  y,
    output logic   overflow,
    output dword_t result_64,
    output logic   hilo_we
);

    // last completed divide
    word_t  mem_a;
    word_t  mem_b;
    aluop_t mem_op;
    dword_t mem_result;

    logic   div_hit;
    dword_t rot;

    // counts leading bits equal to val
    function automatic word_t lead_count(input word_t v, input logic val);
        word_t n;
        logic  done;
        n    = '0;
        done = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!done && v[i] == val)
                n = n + 1'b1;
            else
                done = 1'b1;
        end
        return n;
    endfunction

    assign rot = {b, b} >> a[4:0];    // rotate by 0 gives b back

    assign div_hit = !div.ready && mem_a == a && mem_b == b && mem_op == aluop;

    // operands go straight to the units
    assign mul.a = a;
    assign mul.b = b;
    assign div.a = a;
    assign div.b = b;
    assign mul.sign = (aluop == ALUOP_MULT) || (aluop == ALUOP_MADD) || (aluop == ALUOP_MSUB);
    assign div.sign = (aluop == ALUOP_DIV);

    always_comb begin
        y         = '0;
        overflow  = 1'b0;
        stall     = 1'b0;
        result_64 = '0;
        hilo_we   = 1'b0;
        mul.start = 1'b0;
        div.start = 1'b0;
        case (aluop)
            ALUOP_ADD: begin
                y        = a + b;
                overflow = (a[31] == b[31]) && (y[31] != a[31]);
            end
            ALUOP_ADDU: y = a + b;
            ALUOP_SUB: begin
                y        = a - b;
                overflow = (a[31] != b[31]) && (y[31] != a[31]);
            end
            ALUOP_SUBU:  y = a - b;
            ALUOP_SLT,
            ALUOP_SLTI:  y = {31'b0, $signed(a) < $signed(b)};
            ALUOP_SLTU,
            ALUOP_SLTIU: y = {31'b0, a < b};
            ALUOP_AND:   y = a & b;
            ALUOP_OR:    y = a | b;
            ALUOP_NOR:   y = ~(a | b);
            ALUOP_XOR:   y = a ^ b;
            ALUOP_LUI:   y = {b[15:0], 16'b0};
            ALUOP_SLL,
            ALUOP_SLLV:  y = b << a[4:0];    // amount in a
            ALUOP_SRL,
            ALUOP_SRLV:  y = b >> a[4:0];
            ALUOP_SRA,
            ALUOP_SRAV:  y = $signed(b) >>> a[4:0];
            ALUOP_ROTR:  y = rot[31:0];
            ALUOP_CLO:   y = lead_count(a, 1'b1);
            ALUOP_CLZ:   y = lead_count(a, 1'b0);
            ALUOP_MTHI: begin
                result_64 = {a, hilo[31:0]};
                hilo_we   = 1'b1;
            end
            ALUOP_MTLO: begin
                result_64 = {hilo[63:32], a};
                hilo_we   = 1'b1;
            end
            ALUOP_MFHI: y = hilo[63:32];
            ALUOP_MFLO: y = hilo[31:0];
            ALUOP_MFC0: y = cp0_data;
            ALUOP_MULT, ALUOP_MULTU, ALUOP_MADD,
            ALUOP_MADDU, ALUOP_MSUB, ALUOP_MSUBU: begin
                if (!mul.ready) begin
                    mul.start = 1'b1;
                    stall     = 1'b1;
                end else begin
                    y       = mul.result[31:0];
                    hilo_we = 1'b1;
                    if (aluop == ALUOP_MADD || aluop == ALUOP_MADDU)
                        result_64 = hilo + mul.result;
                    else if (aluop == ALUOP_MSUB || aluop == ALUOP_MSUBU)
                        result_64 = hilo - mul.result;
                    else
                        result_64 = mul.result;
                end
            end
            ALUOP_DIV, ALUOP_DIVU: begin
                if (div_hit) begin
                    y         = mem_result[31:0];    // repeat divide, no stall
                    result_64 = mem_result;
                    hilo_we   = 1'b1;
                end else if (!div.ready) begin
                    div.start = 1'b1;
                    stall     = 1'b1;
                end else begin
                    y         = div.result[31:0];
                    result_64 = div.result;
                    hilo_we   = 1'b1;
                end
            end
            default: y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            mem_op <= ALUOP_NOP;    // never matches a divide
        else if (div.ready)
            mem_op <= aluop;
    end

    always_ff @(posedge clk) begin
        if (div.ready) begin
            mem_a      <= a;
            mem_b      <= b;
            mem_result <= div.result;
        end
    end

endmodule

`default_nettype wire

//--- hilo_file.sv
`timescale 1ns/1ns
`default_nettype none

module hilo_file import alu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   we,
    input  dword_t d,
    output dword_t q
);

    dword_t hilo_q;

    // hi/lo written at the end of the completing cycle
    always_ff @(posedge clk) begin
        if (rst)
            hilo_q <= '0;
        else if (we)
            hilo_q <= d;
    end

    assign q = hilo_q;

endmodule

`default_nettype wire

//--- alu_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_top import alu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  aluop_t aluop,
    input  word_t  a,
    input  word_t  b,
    input  word_t  cp0_data,
    output logic   stall,
    output word_t  y,
    output logic   overflow,
    output dword_t hilo
);

    mul_if mul_bus ();
    div_if div_bus ();

    dword_t result_64;
    logic   hilo_we;

    alu_master u_master (
        .clk       (clk),
        .rst       (rst),
        .aluop     (aluop),
        .a         (a),
        .b         (b),
        .cp0_data  (cp0_data),
        .hilo      (hilo),
        .mul       (mul_bus),
        .div       (div_bus),
        .stall     (stall),
        .y         (y),
        .overflow  (overflow),
        .result_64 (result_64),
        .hilo_we   (hilo_we)
    );

    mul_unit u_mul (
        .clk (clk),
        .rst (rst),
        .mul (mul_bus)
    );

    div_unit u_div (
        .clk (clk),
        .rst (rst),
        .div (div_bus)
    );

    hilo_file u_hilo (
        .clk (clk),
        .rst (rst),
        .we  (hilo_we),
        .d   (result_64),
        .q   (hilo)
    );

endmodule

`default_nettype wire

//--- tb_alu_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_alu_top import alu_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int N_RAND       = 4;    // random pairs per swept code
    localparam int N_SINGLE     = 23;
    // reset reads, sweeps, accumulate run, repeat divides, hi/lo moves, final read
    localparam int NUM_OPS      = (N_SINGLE + 4) * (16 + N_RAND) + 4 * N_RAND + 15;
    localparam int WATCHDOG_NS  = CLK_PERIOD * (NUM_OPS * (DIV_LATENCY + 4) + RESET_CYCLES);

    typedef struct packed {
        word_t  y;
        logic   ov;
        dword_t hilo;
    } result_t;

    logic   clk;
    logic   rst;
    aluop_t aluop;
    word_t  a;
    word_t  b;
    word_t  cp0_data;
    logic   stall;
    word_t  y;
    logic   overflow;
    dword_t hilo;

    int     seed = 39;
    int     n_checks = 0;
    int     n_errors = 0;
    dword_t model_hilo = '0;
    aluop_t last_div_op = ALUOP_NOP;    // model of the divide memory
    word_t  last_div_a = '0;
    word_t  last_div_b = '0;

    word_t  corners [4] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0001};
    aluop_t single_codes [N_SINGLE] = '{
        ALUOP_ADD, ALUOP_ADDU, ALUOP_SUB, ALUOP_SUBU, ALUOP_SLT, ALUOP_SLTU,
        ALUOP_SLTI, ALUOP_SLTIU, ALUOP_AND, ALUOP_OR, ALUOP_NOR, ALUOP_XOR,
        ALUOP_LUI, ALUOP_SLL, ALUOP_SLLV, ALUOP_SRL, ALUOP_SRLV, ALUOP_SRA,
        ALUOP_SRAV, ALUOP_ROTR, ALUOP_CLO, ALUOP_CLZ, ALUOP_MFC0
    };
    aluop_t acc_codes [4] = '{ALUOP_MADD, ALUOP_MADDU, ALUOP_MSUB, ALUOP_MSUBU};

    // driver to checker
    event   compare_ev;
    aluop_t chk_op;
    word_t  chk_a;
    word_t  chk_b;
    word_t  chk_y;
    logic   chk_ov;
    dword_t chk_hilo;
    int     chk_cycles;
    word_t  exp_y;
    logic   exp_ov;
    dword_t exp_hilo;
    int     exp_cycles;

    alu_top i_alu_top (
        .clk      (clk),
        .rst      (rst),
        .aluop    (aluop),
        .a        (a),
        .b        (b),
        .cp0_data (cp0_data),
        .stall    (stall),
        .y        (y),
        .overflow (overflow),
        .hilo     (hilo)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic result_t ref_op(input aluop_t op, input word_t va, input word_t vb,
                                       input word_t cp0, input dword_t hl);
        result_t r;
        longint  s;
        dword_t  p;
        int      sh;
        int      n;
        r.y    = '0;
        r.ov   = 1'b0;
        r.hilo = hl;
        sh     = int'(va[4:0]);    // shift amount comes from a
        n      = 0;
        case (op)
            ALUOP_ADD, ALUOP_SUB: begin
                if (op == ALUOP_ADD)
                    s = longint'($signed(va)) + longint'($signed(vb));
                else
                    s = longint'($signed(va)) - longint'($signed(vb));
                r.y  = s[31:0];
                r.ov = (s > 64'sd2147483647) || (s < -64'sd2147483648);
            end
            ALUOP_ADDU:              r.y = va + vb;
            ALUOP_SUBU:              r.y = va - vb;
            ALUOP_SLT, ALUOP_SLTI:   r.y = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
            ALUOP_SLTU, ALUOP_SLTIU: r.y = (va < vb) ? 32'd1 : 32'd0;
            ALUOP_AND:               r.y = va & vb;
            ALUOP_OR:                r.y = va | vb;
            ALUOP_NOR:               r.y = ~(va | vb);
            ALUOP_XOR:               r.y = va ^ vb;
            ALUOP_LUI:               r.y = vb << 16;
            ALUOP_SLL, ALUOP_SLLV:   r.y = vb << sh;
            ALUOP_SRL, ALUOP_SRLV:   r.y = vb >> sh;
            ALUOP_SRA, ALUOP_SRAV:   r.y = $signed(vb) >>> sh;
            ALUOP_ROTR:              r.y = (sh == 0) ? vb : (vb >> sh) | (vb << (32 - sh));
            ALUOP_CLO, ALUOP_CLZ: begin
                while (n < 32 && va[31 - n] == (op == ALUOP_CLO))
                    n++;
                r.y = word_t'(n);
            end
            ALUOP_MTHI: r.hilo = {va, hl[31:0]};
            ALUOP_MTLO: r.hilo = {hl[63:32], va};
            ALUOP_MFHI: r.y = hl[63:32];
            ALUOP_MFLO: r.y = hl[31:0];
            ALUOP_MFC0: r.y = cp0;
            ALUOP_MULT, ALUOP_MULTU, ALUOP_MADD, ALUOP_MADDU, ALUOP_MSUB, ALUOP_MSUBU: begin
                if (op == ALUOP_MULT || op == ALUOP_MADD || op == ALUOP_MSUB)
                    p = dword_t'(longint'($signed(va)) * longint'($signed(vb)));
                else
                    p = dword_t'(va) * dword_t'(vb);
                r.y = p[31:0];    // plain product, even when accumulating
                if (op == ALUOP_MADD || op == ALUOP_MADDU)
                    r.hilo = hl + p;
                else if (op == ALUOP_MSUB || op == ALUOP_MSUBU)
                    r.hilo = hl - p;
                else
                    r.hilo = p;
            end
            ALUOP_DIV, ALUOP_DIVU: begin
                if (vb == '0) begin
                    p = {va, 32'hffff_ffff};
                end else if (op == ALUOP_DIV) begin
                    s        = longint'($signed(va)) / longint'($signed(vb));
                    p[31:0]  = s[31:0];
                    s        = longint'($signed(va)) % longint'($signed(vb));
                    p[63:32] = s[31:0];
                end else begin
                    p = {va % vb, va / vb};
                end
                r.y    = p[31:0];
                r.hilo = p;
            end
            default: ;
        endcase
        return r;
    endfunction

    function automatic int expected_stall(input aluop_t op, input word_t va, input word_t vb);
        case (op)
            ALUOP_MULT, ALUOP_MULTU, ALUOP_MADD, ALUOP_MADDU, ALUOP_MSUB, ALUOP_MSUBU:
                return MUL_LATENCY;
            ALUOP_DIV, ALUOP_DIVU: begin
                if (op == last_div_op && va == last_div_a && vb == last_div_b)
                    return 0;    // remembered result
                return DIV_LATENCY;
            end
            default: return 0;
        endcase
    endfunction

    task automatic run_op(input aluop_t op, input word_t va, input word_t vb);
        result_t r;
        word_t   cp0;
        int      cycles;
        int      ecyc;
        cp0 = rand_word();
        @(posedge clk);
        aluop    <= op;
        a        <= va;
        b        <= vb;
        cp0_data <= cp0;
        r    = ref_op(op, va, vb, cp0, model_hilo);
        ecyc = expected_stall(op, va, vb);
        @(negedge clk);
        chk_hilo = hilo;    // written by the previous operation
        cycles   = 0;
        while (stall) begin
            cycles++;
            @(negedge clk);
        end
        chk_op     = op;
        chk_a      = va;
        chk_b      = vb;
        chk_y      = y;
        chk_ov     = overflow;
        chk_cycles = cycles;
        exp_y      = r.y;
        exp_ov     = r.ov;
        exp_hilo   = model_hilo;
        exp_cycles = ecyc;
        -> compare_ev;
        model_hilo = r.hilo;
        if (op == ALUOP_DIV || op == ALUOP_DIVU) begin
            last_div_op = op;
            last_div_a  = va;
            last_div_b  = vb;
        end
    endtask

    // all corner pairs, then random ones
    task automatic sweep(input aluop_t op);
        word_t vb;
        for (int i = 0; i < 4; i++)
            for (int j = 0; j < 4; j++)
                run_op(op, corners[i], corners[j]);
        for (int k = 0; k < N_RAND; k++) begin
            vb = rand_word();
            if (op == ALUOP_DIV || op == ALUOP_DIVU)
                vb = vb >> (4 * k);    // smaller divisors, larger quotients
            run_op(op, rand_word(), vb);
        end
    endtask

    always begin
        @(compare_ev);
        n_checks++;
        assert (chk_y === exp_y) else begin
            $display("[FAIL] y: got %h, expected %h (aluop %h a %h b %h)",
                     chk_y, exp_y, chk_op, chk_a, chk_b);
            n_errors++;
        end
        assert (chk_ov === exp_ov) else begin
            $display("[FAIL] overflow: got %h, expected %h (aluop %h a %h b %h)",
                     chk_ov, exp_ov, chk_op, chk_a, chk_b);
            n_errors++;
        end
        assert (chk_hilo === exp_hilo) else begin
            $display("[FAIL] hilo: got %h, expected %h (before aluop %h)",
                     chk_hilo, exp_hilo, chk_op);
            n_errors++;
        end
        assert (chk_cycles == exp_cycles) else begin
            $display("stall was high for %0d cycles instead of %0d on aluop %h",
                     chk_cycles, exp_cycles, chk_op);
            n_errors++;
        end
    end

    initial begin
        word_t v1;
        word_t v2;
        rst      = 1'b1;
        aluop    = ALUOP_NOP;
        a        = '0;
        b        = '0;
        cp0_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (stall === 1'b0) else begin
            $display("[FAIL] stall: got %h, expected 0 after reset", stall);
            n_errors++;
        end
        run_op(ALUOP_MFHI, rand_word(), rand_word());
        run_op(ALUOP_MFLO, rand_word(), rand_word());

        for (int i = 0; i < N_SINGLE; i++)
            sweep(single_codes[i]);
        sweep(ALUOP_MULT);
        sweep(ALUOP_MULTU);

        // accumulate on top of a random hi/lo
        run_op(ALUOP_MTHI, rand_word(), '0);
        run_op(ALUOP_MTLO, rand_word(), '0);
        for (int k = 0; k < N_RAND; k++)
            for (int c = 0; c < 4; c++)
                run_op(acc_codes[c], rand_word(), rand_word());

        sweep(ALUOP_DIV);
        sweep(ALUOP_DIVU);

        v1 = rand_word();
        v2 = rand_word() >> 8;
        run_op(ALUOP_DIV, v1, v2);
        run_op(ALUOP_DIV, v1, v2);         // hit
        run_op(ALUOP_DIV, v1, v2 ^ 32'h1);  // changed divisor
        run_op(ALUOP_DIVU, v2, v1);
        run_op(ALUOP_DIVU, v2, v1);

        run_op(ALUOP_MTHI, rand_word(), '0);
        run_op(ALUOP_MTLO, rand_word(), '0);
        run_op(ALUOP_MFHI, '0, '0);
        run_op(ALUOP_MFLO, '0, '0);
        run_op(ALUOP_MFC0, '0, '0);
        run_op(ALUOP_NOP, '0, '0);    // picks up the last hi/lo write

        @(posedge clk);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: operations did not complete within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
alu_pkg.sv
mul_if.sv
div_if.sv
mul_unit.sv
div_unit.sv
alu_master.sv
hilo_file.sv
alu_top.sv
tb_alu_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu_top -f tb.f
./obj_dir/Vtb_alu_top | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
